/* source/bus_share_pkg.sv */
// Shared bus types and memory map; addresses are byte addresses, word-aligned, no byte enables

`default_nettype none

package bus_share_pkg;

	typedef logic [31:0] word_t;	// Data word on the bus
	typedef logic [31:0] addr_t;	// Byte address, low two bits ignored

	// Arbiter grant state
	typedef enum logic [1:0] {
		ARB_IDLE   = 2'd0,
		ARB_PORT_B = 2'd1,	// Load/store side owns the bus
		ARB_PORT_C = 2'd2	// Fetch side owns the bus
	} arb_state_t;

	// Register block, selected by bit 31
	localparam addr_t IO_BASE           = 32'h8000_0000;
	localparam addr_t IO_SCRATCH_OFFSET = 32'h0000_0000;
	localparam addr_t IO_COUNT_OFFSET   = 32'h0000_0004;	// Read-only

	// Returned for any address that hits neither target
	localparam word_t UNMAPPED_DATA = 32'hdead_beef;

endpackage

`default_nettype wire

/* source/bus_arbiter.sv */
// Fixed priority, port B first; masters must hold request and fields until ready, then drop request

`timescale 1ns/10ps
`default_nettype none

module bus_arbiter import bus_share_pkg::*; (
	input  wire        i_clock,
	input  wire        i_rst_n,

	// Port B, load/store
	input  wire        i_pb_rw,
	input  wire        i_pb_request,
	input  wire addr_t i_pb_address,
	input  wire word_t i_pb_wdata,
	output logic       o_pb_ready,
	output word_t      o_pb_rdata,

	// Port C, instruction fetch
	input  wire        i_pc_rw,
	input  wire        i_pc_request,
	input  wire addr_t i_pc_address,
	input  wire word_t i_pc_wdata,
	output logic       o_pc_ready,
	output word_t      o_pc_rdata,

	// Shared bus
	output logic       o_bus_rw,
	output logic       o_bus_request,
	output addr_t      o_bus_address,
	output word_t      o_bus_wdata,
	input  wire        i_bus_ready,
	input  wire word_t i_bus_rdata
);

	arb_state_t state;
	arb_state_t next_state;
	logic       use_pc;	// Bus fields come from port C

	// Ready only reaches the owner of the bus
	assign o_pb_ready = (state == ARB_PORT_B) && i_pb_request && i_bus_ready;
	assign o_pc_ready = (state == ARB_PORT_C) && i_pc_request && i_bus_ready;

	// Read data only matters in the ready cycle
	assign o_pb_rdata = i_bus_rdata;
	assign o_pc_rdata = i_bus_rdata;

	// In idle, show the fields of whoever would win
	assign use_pc = (state == ARB_PORT_C) ||
		((state == ARB_IDLE) && !i_pb_request && i_pc_request);

	assign o_bus_rw      = use_pc ? i_pc_rw      : i_pb_rw;
	assign o_bus_address = use_pc ? i_pc_address : i_pb_address;
	assign o_bus_wdata   = use_pc ? i_pc_wdata   : i_pb_wdata;

	assign o_bus_request = ((state == ARB_PORT_B) && i_pb_request) ||
		((state == ARB_PORT_C) && i_pc_request);

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ARB_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			ARB_IDLE: begin
				if (i_pb_request) begin	// B wins a tie
					next_state = ARB_PORT_B;
				end else if (i_pc_request) begin
					next_state = ARB_PORT_C;
				end
			end
			ARB_PORT_B, ARB_PORT_C: begin
				// Back to idle after ready, so grants are spaced by a cycle
				if (i_bus_ready) begin
					next_state = ARB_IDLE;
				end
			end
			default: next_state = ARB_IDLE;
		endcase
	end

endmodule

`default_nettype wire

/* source/bus_decoder.sv */
// Bit 31 selects registers, low SRAM_ADDR_BITS+2 bits the SRAM; the rest is unmapped and read-only

`timescale 1ns/10ps
`default_nettype none

module bus_decoder import bus_share_pkg::*; #(
	parameter int SRAM_ADDR_BITS = 8
) (
	input  wire        i_clock,
	input  wire        i_rst_n,

	// Shared bus from the arbiter
	input  wire        i_bus_rw,
	input  wire        i_bus_request,
	input  wire addr_t i_bus_address,
	input  wire word_t i_bus_wdata,
	output logic       o_bus_ready,
	output word_t      o_bus_rdata,

	// SRAM target
	output logic       o_sram_request,
	output logic       o_sram_rw,
	output addr_t      o_sram_address,
	output word_t      o_sram_wdata,
	input  wire        i_sram_ready,
	input  wire word_t i_sram_rdata,

	// Register target
	output logic       o_io_request,
	output logic       o_io_rw,
	output addr_t      o_io_address,
	output word_t      o_io_wdata,
	input  wire        i_io_ready,
	input  wire word_t i_io_rdata
);

	logic sel_io;
	logic sel_sram;
	logic unmapped_ready;

	assign sel_io   = i_bus_address[31] == IO_BASE[31];
	assign sel_sram = !sel_io && ((i_bus_address >> (SRAM_ADDR_BITS + 2)) == '0);

	assign o_sram_request = i_bus_request && sel_sram;
	assign o_sram_rw      = i_bus_rw;
	assign o_sram_address = i_bus_address;
	assign o_sram_wdata   = i_bus_wdata;

	assign o_io_request = i_bus_request && sel_io;
	assign o_io_rw      = i_bus_rw;
	assign o_io_address = i_bus_address;
	assign o_io_wdata   = i_bus_wdata;

	// Unmapped space answers one cycle after request, writes dropped
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			unmapped_ready <= 1'b0;
		end else begin
			unmapped_ready <= i_bus_request && !sel_io && !sel_sram && !unmapped_ready;
		end
	end

	// Address is held for the whole transfer, so the select is stable here
	assign o_bus_ready = sel_io ? i_io_ready : (sel_sram ? i_sram_ready : unmapped_ready);
	assign o_bus_rdata = sel_io ? i_io_rdata : (sel_sram ? i_sram_rdata : UNMAPPED_DATA);

endmodule

`default_nettype wire

/* source/sram_target.sv */
// Ready SRAM_WAIT+1 cycles after request; contents undefined until written, no byte enables

`timescale 1ns/10ps
`default_nettype none

module sram_target import bus_share_pkg::*; #(
	parameter int SRAM_ADDR_BITS = 8,
	parameter int SRAM_WAIT      = 2
) (
	input  wire        i_clock,
	input  wire        i_rst_n,
	input  wire        i_request,
	input  wire        i_rw,
	input  wire addr_t i_address,
	input  wire word_t i_wdata,
	output logic       o_ready,
	output word_t      o_rdata
);

	localparam int DEPTH     = 2 ** SRAM_ADDR_BITS;
	localparam int WAIT_BITS = (SRAM_WAIT > 0) ? $clog2(SRAM_WAIT + 1) : 1;

	typedef logic [SRAM_ADDR_BITS-1:0] sram_index_t;
	typedef logic [WAIT_BITS-1:0] wait_count_t;

	word_t       mem [DEPTH];
	sram_index_t index;
	wait_count_t wait_count;
	logic        last_wait;

	assign index     = i_address[SRAM_ADDR_BITS+1:2];	// Word address
	assign last_wait = i_request && !o_ready && (wait_count == wait_count_t'(SRAM_WAIT));

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wait_count <= '0;
			o_ready    <= 1'b0;
		end else if (last_wait) begin
			wait_count <= '0;	// Fresh count for the next request
			o_ready    <= 1'b1;
		end else if (i_request && !o_ready) begin
			wait_count <= wait_count + 1'b1;
			o_ready    <= 1'b0;
		end else begin
			wait_count <= '0;
			o_ready    <= 1'b0;
		end
	end

	// Access lands on the edge that raises ready
	always_ff @(posedge i_clock) begin
		if (last_wait) begin
			if (i_rw) begin
				mem[index] <= i_wdata;
			end
			o_rdata <= mem[index];	// Old contents on a write
		end
	end

endmodule

`default_nettype wire

/* source/io_registers.sv */
// Offset 0 is scratch, offset 4 counts every register write; other offsets read zero, ignore writes

`timescale 1ns/10ps
`default_nettype none

module io_registers import bus_share_pkg::*; (
	input  wire        i_clock,
	input  wire        i_rst_n,
	input  wire        i_request,
	input  wire        i_rw,
	input  wire addr_t i_address,
	input  wire word_t i_wdata,
	output logic       o_ready,
	output word_t      o_rdata
);

	word_t scratch;
	word_t write_count;
	addr_t offset;
	logic  access;	// Edge that answers the request

	assign offset = {i_address[31:2], 2'b00} & ~IO_BASE;
	assign access = i_request && !o_ready;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_ready     <= 1'b0;
			write_count <= '0;
		end else begin
			o_ready <= access;
			if (access && i_rw) begin
				write_count <= write_count + 1'b1;	// Counts ignored writes too
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			if (i_rw && (offset == IO_SCRATCH_OFFSET)) begin
				scratch <= i_wdata;
			end
			if (offset == IO_SCRATCH_OFFSET) begin
				o_rdata <= scratch;
			end else if (offset == IO_COUNT_OFFSET) begin
				o_rdata <= write_count;
			end else begin
				o_rdata <= '0;
			end
		end
	end

endmodule

`default_nettype wire

/* source/bus_share_top.sv */
// Two masters on one bus; lone-port latency is 2+SRAM_WAIT cycles to SRAM, 2 to registers

`timescale 1ns/10ps
`default_nettype none

module bus_share_top import bus_share_pkg::*; #(
	parameter int SRAM_ADDR_BITS = 8,	// 256 words by default
	parameter int SRAM_WAIT      = 2
) (
	input  wire        i_clock,
	input  wire        i_rst_n,

	// Port B, load/store
	input  wire        i_pb_rw,
	input  wire        i_pb_request,
	input  wire addr_t i_pb_address,
	input  wire word_t i_pb_wdata,
	output logic       o_pb_ready,
	output word_t      o_pb_rdata,

	// Port C, instruction fetch
	input  wire        i_pc_rw,
	input  wire        i_pc_request,
	input  wire addr_t i_pc_address,
	input  wire word_t i_pc_wdata,
	output logic       o_pc_ready,
	output word_t      o_pc_rdata
);

	// Shared bus
	logic  bus_rw;
	logic  bus_request;
	addr_t bus_address;
	word_t bus_wdata;
	logic  bus_ready;
	word_t bus_rdata;

	// SRAM side
	logic  sram_request;
	logic  sram_rw;
	addr_t sram_address;
	word_t sram_wdata;
	logic  sram_ready;
	word_t sram_rdata;

	// Register side
	logic  io_request;
	logic  io_rw;
	addr_t io_address;
	word_t io_wdata;
	logic  io_ready;
	word_t io_rdata;

	bus_arbiter u_arbiter (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_pb_rw       (i_pb_rw),
		.i_pb_request  (i_pb_request),
		.i_pb_address  (i_pb_address),
		.i_pb_wdata    (i_pb_wdata),
		.o_pb_ready    (o_pb_ready),
		.o_pb_rdata    (o_pb_rdata),
		.i_pc_rw       (i_pc_rw),
		.i_pc_request  (i_pc_request),
		.i_pc_address  (i_pc_address),
		.i_pc_wdata    (i_pc_wdata),
		.o_pc_ready    (o_pc_ready),
		.o_pc_rdata    (o_pc_rdata),
		.o_bus_rw      (bus_rw),
		.o_bus_request (bus_request),
		.o_bus_address (bus_address),
		.o_bus_wdata   (bus_wdata),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata)
	);

	bus_decoder #(
		.SRAM_ADDR_BITS (SRAM_ADDR_BITS)
	) u_decoder (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_bus_rw       (bus_rw),
		.i_bus_request  (bus_request),
		.i_bus_address  (bus_address),
		.i_bus_wdata    (bus_wdata),
		.o_bus_ready    (bus_ready),
		.o_bus_rdata    (bus_rdata),
		.o_sram_request (sram_request),
		.o_sram_rw      (sram_rw),
		.o_sram_address (sram_address),
		.o_sram_wdata   (sram_wdata),
		.i_sram_ready   (sram_ready),
		.i_sram_rdata   (sram_rdata),
		.o_io_request   (io_request),
		.o_io_rw        (io_rw),
		.o_io_address   (io_address),
		.o_io_wdata     (io_wdata),
		.i_io_ready     (io_ready),
		.i_io_rdata     (io_rdata)
	);

	sram_target #(
		.SRAM_ADDR_BITS (SRAM_ADDR_BITS),
		.SRAM_WAIT      (SRAM_WAIT)
	) u_sram (
		.i_clock   (i_clock),
		.i_rst_n   (i_rst_n),
		.i_request (sram_request),
		.i_rw      (sram_rw),
		.i_address (sram_address),
		.i_wdata   (sram_wdata),
		.o_ready   (sram_ready),
		.o_rdata   (sram_rdata)
	);

	io_registers u_io (
		.i_clock   (i_clock),
		.i_rst_n   (i_rst_n),
		.i_request (io_request),
		.i_rw      (io_rw),
		.i_address (io_address),
		.i_wdata   (io_wdata),
		.o_ready   (io_ready),
		.o_rdata   (io_rdata)
	);

endmodule

`default_nettype wire

/* test/bus_share_tb.sv */
// Assumes default DUT parameters (256 words, 2 wait states); reads only SRAM words it wrote first

`timescale 1ns/10ps
`default_nettype none

module bus_share_tb import bus_share_pkg::*; ();

	localparam int SRAM_ADDR_BITS = 8;
	localparam int SRAM_WAIT      = 2;
	localparam int SRAM_WORDS     = 2 ** SRAM_ADDR_BITS;
	localparam int TIMEOUT_CYCLES = 4000;	// Tests need well under 1000 cycles

	logic  clock;
	logic  rst_n;
	logic  pb_rw;
	logic  pb_request;
	addr_t pb_address;
	word_t pb_wdata;
	logic  pb_ready;
	word_t pb_rdata;
	logic  pc_rw;
	logic  pc_request;
	addr_t pc_address;
	word_t pc_wdata;
	logic  pc_ready;
	word_t pc_rdata;

	// Model of what the DUT should hold
	word_t sram_model [SRAM_WORDS];
	word_t scratch_model;
	word_t count_model = '0;

	word_t lfsr_state  = 32'h21aa_6e71;
	int    cycle_count = 0;
	string test_name   = "reset";

	bus_share_top DUT (
		.i_clock      (clock),
		.i_rst_n      (rst_n),
		.i_pb_rw      (pb_rw),
		.i_pb_request (pb_request),
		.i_pb_address (pb_address),
		.i_pb_wdata   (pb_wdata),
		.o_pb_ready   (pb_ready),
		.o_pb_rdata   (pb_rdata),
		.i_pc_rw      (pc_rw),
		.i_pc_request (pc_request),
		.i_pc_address (pc_address),
		.i_pc_wdata   (pc_wdata),
		.o_pc_ready   (pc_ready),
		.o_pc_rdata   (pc_rdata)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic word_t take_bits(input int count);
		word_t value;
		logic  feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], feedback};
			value      = {value[30:0], feedback};
		end
		return value;
	endfunction

	// SRAM covers the byte addresses below four times its word count
	function automatic logic in_sram(input addr_t address);
		return address < addr_t'(SRAM_WORDS * 4);
	endfunction

	// Expected read data from the memory map rules
	function automatic word_t expected_read(input addr_t address);
		if (address[31]) begin
			if (address[30:2] == '0) begin
				return scratch_model;	// Offset 0
			end else if (address[30:2] == 29'd1) begin
				return count_model;	// Offset 4
			end
			return '0;
		end else if (in_sram(address)) begin
			return sram_model[address[SRAM_ADDR_BITS+1:2]];
		end
		return UNMAPPED_DATA;
	endfunction

	task automatic record_write(input addr_t address, input word_t data);
		if (address[31]) begin
			count_model = count_model + 1;	// Every register write counts
			if (address[30:2] == '0) begin
				scratch_model = data;
			end
		end else if (in_sram(address)) begin
			sram_model[address[SRAM_ADDR_BITS+1:2]] = data;
		end
	endtask

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (expected !== actual) begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic compare_response(input logic rw, input addr_t address, input word_t wdata,
			input word_t rdata);
		if (rw) begin
			record_write(address, wdata);
		end else begin
			check_value(test_name, expected_read(address), rdata);
		end
	endtask

	// Every completed transfer updates the model or is checked against it
	always @(negedge clock) begin
		if (rst_n && pb_ready) begin
			compare_response(pb_rw, pb_address, pb_wdata, pb_rdata);
		end
		if (rst_n && pc_ready) begin
			compare_response(pc_rw, pc_address, pc_wdata, pc_rdata);
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation finished: FAIL");
			$fatal(1, "timeout");
		end
	end

	// Latency counts edges from the request edge to the ready cycle
	task automatic port_b_transfer(input logic rw, input addr_t address, input word_t wdata,
			output word_t rdata, output int latency);
		latency = 0;
		@(posedge clock);
		pb_rw      <= rw;
		pb_address <= address;
		pb_wdata   <= wdata;
		pb_request <= 1'b1;
		@(negedge clock);
		while (!pb_ready) begin
			latency++;
			@(negedge clock);
		end
		rdata = pb_rdata;
		@(posedge clock);
		pb_request <= 1'b0;	// Low for at least one cycle
	endtask

	task automatic port_c_transfer(input logic rw, input addr_t address, input word_t wdata,
			output word_t rdata, output int latency);
		latency = 0;
		@(posedge clock);
		pc_rw      <= rw;
		pc_address <= address;
		pc_wdata   <= wdata;
		pc_request <= 1'b1;
		@(negedge clock);
		while (!pc_ready) begin
			latency++;
			@(negedge clock);
		end
		rdata = pc_rdata;
		@(posedge clock);
		pc_request <= 1'b0;
	endtask

	// Random writes and reads, B in the lower SRAM half and C in the upper
	task automatic random_mix(input logic use_c);
		addr_t written[$];
		addr_t address;
		word_t data;
		word_t rdata;
		int    latency;
		for (int i = 0; i < 24; i++) begin
			repeat (take_bits(2)) @(posedge clock);
			if (written.size() == 0 || take_bits(1)) begin
				address = (take_bits(7) + (use_c ? 128 : 0)) << 2;
				data    = take_bits(32);
				written.push_back(address);
			end else begin
				address = written[take_bits(5) % written.size()];
				data    = '0;
			end
			if (use_c) begin
				port_c_transfer(data != '0, address, data, rdata, latency);
			end else begin
				port_b_transfer(data != '0, address, data, rdata, latency);
			end
		end
	endtask

	initial begin
		addr_t b_written[$];
		addr_t address;
		word_t data;
		word_t rdata;
		word_t c_rdata;
		int    latency;
		int    b_latency;
		int    c_latency;
		int    io_writes;
		io_writes  = 0;
		rst_n      = 1'b0;
		pb_rw      = 1'b0;
		pb_request = 1'b0;
		pb_address = '0;
		pb_wdata   = '0;
		pc_rw      = 1'b0;
		pc_request = 1'b0;
		pc_address = '0;
		pc_wdata   = '0;
		repeat (8) @(posedge clock);
		rst_n <= 1'b1;

		test_name = "idle after reset";
		repeat (20) begin
			@(negedge clock);
			check_value(test_name, '0, word_t'({pb_ready, pc_ready}));
		end

		test_name = "sram write read";
		for (int i = 0; i < 32; i++) begin
			address = (take_bits(SRAM_ADDR_BITS) << 2) | take_bits(2);	// Low bits ignored
			data    = take_bits(32);
			port_b_transfer(1'b1, address, data, rdata, latency);
			b_written.push_back(address);
		end
		foreach (b_written[i]) begin
			port_b_transfer(1'b0, b_written[i], '0, rdata, latency);
		end

		// A zero data word would be taken as a read, so the mix never writes zero
		test_name = "parallel ports";
		fork
			random_mix(1'b0);
			random_mix(1'b1);
		join

		test_name = "priority";
		fork
			port_b_transfer(1'b0, b_written[0], '0, rdata, b_latency);
			port_c_transfer(1'b0, b_written[1], '0, c_rdata, c_latency);
		join
		check_value(test_name, 32'd1, word_t'(b_latency < c_latency));

		test_name = "register block";
		data = take_bits(32);
		port_b_transfer(1'b1, IO_BASE, data, rdata, latency);
		io_writes++;
		port_b_transfer(1'b0, IO_BASE, '0, rdata, latency);
		check_value(test_name, data, rdata);
		port_c_transfer(1'b1, IO_BASE | 32'h4, take_bits(32), rdata, latency);	// Count only
		io_writes++;
		port_b_transfer(1'b0, IO_BASE, '0, rdata, latency);
		check_value("scratch kept", data, rdata);
		port_c_transfer(1'b0, IO_BASE | 32'h4, '0, rdata, latency);
		check_value("write count", word_t'(io_writes), rdata);

		test_name = "unmapped read";
		port_c_transfer(1'b0, 32'h0001_0000, '0, rdata, latency);
		check_value(test_name, UNMAPPED_DATA, rdata);

		test_name = "sram latency";
		port_b_transfer(1'b0, b_written[2], '0, rdata, latency);
		check_value(test_name, word_t'(2 + SRAM_WAIT), word_t'(latency));

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* bus_share.f */
source/bus_share_pkg.sv
source/bus_arbiter.sv
source/bus_decoder.sv
source/sram_target.sv
source/io_registers.sv
source/bus_share_top.sv
test/bus_share_tb.sv

/* Bender.yml */
package:
  name: bus_share

sources:
  # Package
  - files:
      - source/bus_share_pkg.sv
  # RTL
  - files:
      - source/bus_arbiter.sv
      - source/bus_decoder.sv
      - source/sram_target.sv
      - source/io_registers.sv
      - source/bus_share_top.sv
  # Testbench
  - target: test
    files:
      - test/bus_share_tb.sv
